/* hw/cam_config.svh */
`ifndef CAM_CONFIG_SVH
`define CAM_CONFIG_SVH

// ----------------------------------------
//  stream geometry
// ----------------------------------------

`define CAM_RAW_W       10      // sensor pixel
`define CAM_PIX_W       8       // pixel after reduction
`define CAM_WORD_PIX    4       // pixels per packed word
`define CAM_CNT_W       16

// ----------------------------------------
//  register bus and map
// ----------------------------------------

`define CAM_WB_ADR_W    8
`define CAM_WB_DAT_W    32

`define CAM_CORE_ID     32'h01234567

`define CAM_REG_ID      8'h00
`define CAM_REG_CTRL    8'h01   // bit0 enable, bit1 sw reset
`define CAM_REG_WIDTH   8'h02
`define CAM_REG_FILL    8'h03
`define CAM_REG_FRAMES  8'h04

`define CAM_INIT_WIDTH  16
`define CAM_INIT_FILL   0

`endif

/* hw/cam_stream_pkg.sv */
`include "cam_config.svh"

package cam_stream_pkg;

    // single raw pixel as it leaves the receiver
    typedef logic [`CAM_RAW_W-1:0] raw_pix_t;

    // four reduced pixels, byte 0 first
    typedef logic [`CAM_WORD_PIX*`CAM_PIX_W-1:0] word_t;

    // pixel position in a line, or frame count
    typedef logic [`CAM_CNT_W-1:0] count_t;

    typedef struct packed {
        logic     sof;      // first pixel of a frame
        logic     eol;      // last pixel of a line
        raw_pix_t pix;
    } raw_beat_t;

    typedef struct packed {
        logic  sof;         // word holds the frame's first pixel
        logic  eol;         // word ends a line
        word_t data;
    } word_beat_t;

endpackage

/* hw/cam_regs_pkg.sv */
`include "cam_config.svh"

package cam_regs_pkg;

    typedef logic [`CAM_WB_ADR_W-1:0] wb_adr_t;
    typedef logic [`CAM_WB_DAT_W-1:0] wb_dat_t;

    // host side of the register bus, held until ack
    typedef struct packed {
        wb_adr_t adr;
        wb_dat_t dat;
        logic    we;
        logic    stb;
    } wb_req_t;

    // settings steering the stream stages
    typedef struct packed {
        logic                     enable;
        cam_stream_pkg::count_t   width;    // pixels per line, multiple of 4
        cam_stream_pkg::raw_pix_t fill;     // pad value for short lines
    } stream_cfg_t;

endpackage

/* hw/cam_reg_block.sv */
`include "cam_config.svh"

module cam_reg_block (
    input  logic                      axi4s_cam_aclk,
    input  logic                      sys_reset,
    input  cam_regs_pkg::wb_req_t     wb_req_i,
    output cam_regs_pkg::wb_dat_t     wb_dat_o,
    output logic                      wb_ack_o,
    input  logic                      frame_done_i,
    output cam_regs_pkg::stream_cfg_t cfg_o,
    output logic                      clear_o
);

    logic                     ack_q;
    cam_regs_pkg::wb_dat_t    dat_q;
    logic                     access;
    cam_regs_pkg::wb_dat_t    rd_data;
    logic                     enable_q;
    logic                     sw_reset_q;
    cam_stream_pkg::count_t   width_q;
    cam_stream_pkg::raw_pix_t fill_q;
    cam_stream_pkg::count_t   frames_q;

    // ----------------------------------------
    //  bus decode
    // ----------------------------------------

    assign access = wb_req_i.stb && !ack_q;     // first sampled cycle only

    always_comb begin
        case (wb_req_i.adr)
            `CAM_REG_ID:     rd_data = `CAM_CORE_ID;
            `CAM_REG_CTRL:   rd_data = cam_regs_pkg::wb_dat_t'({sw_reset_q, enable_q});
            `CAM_REG_WIDTH:  rd_data = cam_regs_pkg::wb_dat_t'(width_q);
            `CAM_REG_FILL:   rd_data = cam_regs_pkg::wb_dat_t'(fill_q);
            `CAM_REG_FRAMES: rd_data = cam_regs_pkg::wb_dat_t'(frames_q);
            default:         rd_data = '0;     // unmapped reads as zero
        endcase
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (access) begin
            dat_q <= rd_data;
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = dat_q;

    // ----------------------------------------
    //  control and configuration
    // ----------------------------------------

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset) begin
            enable_q   <= 1'b0;
            sw_reset_q <= 1'b0;
            width_q    <= cam_stream_pkg::count_t'(`CAM_INIT_WIDTH);
            fill_q     <= cam_stream_pkg::raw_pix_t'(`CAM_INIT_FILL);
        end else begin
            sw_reset_q <= 1'b0;     // one cycle pulse
            if (access && wb_req_i.we) begin
                case (wb_req_i.adr)
                    `CAM_REG_CTRL: begin
                        enable_q   <= wb_req_i.dat[0];
                        sw_reset_q <= wb_req_i.dat[1];
                    end
                    `CAM_REG_WIDTH: width_q <= {wb_req_i.dat[`CAM_CNT_W-1:2], 2'b00};
                    `CAM_REG_FILL:  fill_q  <= wb_req_i.dat[`CAM_RAW_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    assign clear_o = sys_reset || sw_reset_q;

    // frames seen at the packed output
    always_ff @(posedge axi4s_cam_aclk) begin
        if (clear_o) begin
            frames_q <= '0;
        end else if (frame_done_i) begin
            frames_q <= frames_q + 1'b1;
        end
    end

    assign cfg_o = '{enable: enable_q, width: width_q, fill: fill_q};

    // host drops stb after ack, so a second ack in a row means a decode fault
    ack_one_cycle: assert property (@(posedge axi4s_cam_aclk) disable iff (sys_reset)
        wb_ack_o |=> !wb_ack_o);

endmodule

/* hw/line_regularizer.sv */
module line_regularizer (
    input  logic                      axi4s_cam_aclk,
    input  logic                      clear_i,
    input  cam_regs_pkg::stream_cfg_t cfg_i,
    input  cam_stream_pkg::raw_beat_t s_beat_i,
    input  logic                      s_valid_i,
    output logic                      s_ready_o,
    output cam_stream_pkg::raw_beat_t m_beat_o,
    output logic                      m_valid_o,
    input  logic                      m_ready_i
);

    typedef enum logic [1:0] {
        PASS,   // forward and count
        PAD,    // fill up a short line
        SKIP,   // discard the tail of a long line
        DROP    // disabled, wait for a frame start
    } state_t;

    state_t                    state_q;
    cam_stream_pkg::count_t    cnt_q;       // pixels sent in this line
    cam_stream_pkg::count_t    cnt_nxt;
    cam_stream_pkg::raw_beat_t beat_q;
    logic                      valid_q;
    logic                      out_free;
    logic                      at_width;
    logic                      start_ok;
    logic                      in_fire;
    logic                      take;
    logic                      pad_fire;

    assign out_free = !valid_q || m_ready_i;
    assign cnt_nxt  = cnt_q + 1'b1;
    assign at_width = (cnt_nxt == cfg_i.width);
    assign start_ok = cfg_i.enable && s_beat_i.sof;

    always_comb begin
        case (state_q)
            PASS:    s_ready_o = out_free && (cnt_q != '0 || cfg_i.enable);
            PAD:     s_ready_o = 1'b0;
            SKIP:    s_ready_o = 1'b1;
            default: s_ready_o = !start_ok || out_free;
        endcase
    end

    assign in_fire  = s_valid_i && s_ready_o;
    assign take     = in_fire && (state_q == PASS || (state_q == DROP && start_ok));
    assign pad_fire = (state_q == PAD) && out_free;

    // ----------------------------------------
    //  state machine
    // ----------------------------------------

    always_ff @(posedge axi4s_cam_aclk) begin
        if (clear_i) begin
            state_q <= DROP;
            cnt_q   <= '0;
        end else begin
            if (take) begin
                if (at_width) begin
                    cnt_q   <= '0;
                    state_q <= s_beat_i.eol ? PASS : SKIP;
                end else begin
                    cnt_q   <= cnt_nxt;
                    state_q <= s_beat_i.eol ? PAD : PASS;    // early eol pads
                end
            end else if (pad_fire) begin
                cnt_q <= at_width ? '0 : cnt_nxt;
                if (at_width) begin
                    state_q <= PASS;
                end
            end else if (state_q == SKIP && in_fire && s_beat_i.eol) begin
                state_q <= PASS;
            end else if (state_q == PASS && cnt_q == '0 && !cfg_i.enable) begin
                state_q <= DROP;    // only between lines
            end
        end
    end

    // ----------------------------------------
    //  output register
    // ----------------------------------------

    always_ff @(posedge axi4s_cam_aclk) begin
        if (clear_i) begin
            valid_q <= 1'b0;
        end else if (take || pad_fire) begin
            valid_q <= 1'b1;
        end else if (m_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (take) begin
            beat_q.pix <= s_beat_i.pix;
            beat_q.sof <= s_beat_i.sof && (cnt_q == '0);
            beat_q.eol <= at_width;     // truncation point
        end else if (pad_fire) begin
            beat_q.pix <= cfg_i.fill;
            beat_q.sof <= 1'b0;
            beat_q.eol <= at_width;
        end
    end

    assign m_beat_o  = beat_q;
    assign m_valid_o = valid_q;

    hold_while_stalled: assert property (@(posedge axi4s_cam_aclk) disable iff (clear_i)
        m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_beat_o));

endmodule

/* hw/pixel_packer.sv */
`include "cam_config.svh"

module pixel_packer (
    input  logic                       axi4s_cam_aclk,
    input  logic                       clear_i,
    input  cam_stream_pkg::raw_beat_t  s_beat_i,
    input  logic                       s_valid_i,
    output logic                       s_ready_o,
    output cam_stream_pkg::word_beat_t m_beat_o,
    output logic                       m_valid_o,
    input  logic                       m_ready_i
);

    localparam int IDX_W = $clog2(`CAM_WORD_PIX);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`CAM_WORD_PIX - 1);

    logic [IDX_W-1:0]                         idx_q;
    logic [`CAM_WORD_PIX-2:0][`CAM_PIX_W-1:0] acc_q;    // bytes 0..2 of the next word
    logic                                     sof_q;
    cam_stream_pkg::word_beat_t               beat_q;
    logic                                     valid_q;
    logic [`CAM_PIX_W-1:0]                    top_bits;
    logic                                     last_pix;
    logic                                     out_free;
    logic                                     in_fire;

    assign top_bits = s_beat_i.pix[`CAM_RAW_W-1 -: `CAM_PIX_W];
    assign last_pix = (idx_q == LAST_IDX);
    assign out_free = !valid_q || m_ready_i;

    // first three pixels go to the accumulator even while a word waits
    assign s_ready_o = !last_pix || out_free;
    assign in_fire   = s_valid_i && s_ready_o;

    always_ff @(posedge axi4s_cam_aclk) begin
        if (clear_i) begin
            idx_q <= '0;
        end else if (in_fire) begin
            idx_q <= last_pix ? '0 : idx_q + 1'b1;
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (in_fire && !last_pix) begin
            acc_q[idx_q] <= top_bits;
        end
        if (in_fire && idx_q == '0) begin
            sof_q <= s_beat_i.sof;
        end
        if (in_fire && last_pix) begin
            beat_q <= '{sof: sof_q, eol: s_beat_i.eol, data: {top_bits, acc_q}};
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (clear_i) begin
            valid_q <= 1'b0;
        end else if (in_fire && last_pix) begin
            valid_q <= 1'b1;
        end else if (m_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    assign m_beat_o  = beat_q;
    assign m_valid_o = valid_q;

    // the regularizer keeps lines a multiple of four pixels
    eol_on_word_end: assert property (@(posedge axi4s_cam_aclk) disable iff (clear_i)
        in_fire && s_beat_i.eol |-> last_pix);

endmodule

/* hw/cam_capture_top.sv */
module cam_capture_top (
    input  logic                       axi4s_cam_aclk,
    input  logic                       sys_reset,

    input  cam_regs_pkg::wb_req_t      wb_req_i,
    output cam_regs_pkg::wb_dat_t      wb_dat_o,
    output logic                       wb_ack_o,

    input  cam_stream_pkg::raw_beat_t  s_beat_i,
    input  logic                       s_valid_i,
    output logic                       s_ready_o,

    output cam_stream_pkg::word_beat_t m_beat_o,
    output logic                       m_valid_o,
    input  logic                       m_ready_i
);

    cam_regs_pkg::stream_cfg_t cfg;
    logic                      clear;
    logic                      frame_done;
    cam_stream_pkg::raw_beat_t reg_beat;    // regularizer -> packer
    logic                      reg_valid;
    logic                      reg_ready;

    // one count per frame start leaving toward the DMA
    assign frame_done = m_valid_o && m_ready_i && m_beat_o.sof;

    cam_reg_block i_reg_block (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .sys_reset      (sys_reset),
        .wb_req_i       (wb_req_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .frame_done_i   (frame_done),
        .cfg_o          (cfg),
        .clear_o        (clear)
    );

    line_regularizer i_line_regularizer (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .clear_i        (clear),
        .cfg_i          (cfg),
        .s_beat_i       (s_beat_i),
        .s_valid_i      (s_valid_i),
        .s_ready_o      (s_ready_o),
        .m_beat_o       (reg_beat),
        .m_valid_o      (reg_valid),
        .m_ready_i      (reg_ready)
    );

    pixel_packer i_pixel_packer (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .clear_i        (clear),
        .s_beat_i       (reg_beat),
        .s_valid_i      (reg_valid),
        .s_ready_o      (reg_ready),
        .m_beat_o       (m_beat_o),
        .m_valid_o      (m_valid_o),
        .m_ready_i      (m_ready_i)
    );

endmodule

/* verif/cam_ref_model.svh */
`ifndef CAM_REF_MODEL_SVH
`define CAM_REF_MODEL_SVH

`include "cam_config.svh"

// ----------------------------------------
//  expected output words
// ----------------------------------------

typedef cam_stream_pkg::raw_pix_t pix_list_t[$];

cam_stream_pkg::word_beat_t exp_words[$];   // oldest first

// pixel i after the line is cut or padded to the width
function automatic cam_stream_pkg::raw_pix_t fitted_pix(input pix_list_t line, input int i,
        input cam_stream_pkg::raw_pix_t fill);
    if (i < line.size()) begin
        return line[i];
    end
    return fill;    // past the end of a short line
endfunction

function automatic logic [`CAM_PIX_W-1:0] top_bits(input cam_stream_pkg::raw_pix_t pix);
    logic [`CAM_RAW_W-1:0] shifted;
    shifted = pix >> (`CAM_RAW_W - `CAM_PIX_W);
    return shifted[`CAM_PIX_W-1:0];
endfunction

// one input line gives width/4 words, sof only on the first, eol on the last
function automatic void queue_line(input pix_list_t line, input logic sof, input int width,
        input cam_stream_pkg::raw_pix_t fill);
    cam_stream_pkg::word_beat_t word;
    cam_stream_pkg::raw_pix_t   pix;
    int                         n_words;
    int                         w;
    int                         k;
    n_words = width / `CAM_WORD_PIX;
    for (w = 0; w < n_words; w++) begin
        word.data = '0;
        for (k = 0; k < `CAM_WORD_PIX; k++) begin
            pix = fitted_pix(line, w * `CAM_WORD_PIX + k, fill);
            word.data[k*`CAM_PIX_W +: `CAM_PIX_W] = top_bits(pix);    // arrival order
        end
        word.sof = sof && (w == 0);
        word.eol = (w == n_words - 1);
        exp_words.push_back(word);
    end
endfunction

`endif

/* verif/tb_cam_capture.sv */
`include "cam_config.svh"

module tb_cam_capture;
    timeunit 1ns;
    timeprecision 100ps;

    `include "cam_ref_model.svh"

    localparam int LINE_BEATS  = 64;                // input plus pad pixels, upper bound
    localparam int N_LINES     = 8 + 8 + 8 + 24 + 4;
    localparam int CYCLE_LIMIT = 4 * N_LINES * LINE_BEATS + 2000;

    logic                       axi4s_cam_aclk = 1'b0;
    logic                       sys_reset;
    cam_regs_pkg::wb_req_t      wb_req_i;
    cam_regs_pkg::wb_dat_t      wb_dat_o;
    logic                       wb_ack_o;
    cam_stream_pkg::raw_beat_t  s_beat_i;
    logic                       s_valid_i;
    logic                       s_ready_o;
    cam_stream_pkg::word_beat_t m_beat_o;
    logic                       m_valid_o;
    logic                       m_ready_i;
    int  cycle_cnt = 0;
    int  err_cnt = 0;
    int  err_mark = 0;
    int  chk_cnt = 0;
    int  tests_run = 0;
    int  fail_tests = 0;
    int  frames_sent = 0;
    bit  random_ready = 1'b0;
    int  cfg_width;
    cam_stream_pkg::raw_pix_t cfg_fill;

    cam_capture_top dut_i (.*);

    always #4 axi4s_cam_aclk = ~axi4s_cam_aclk;

    always @(posedge axi4s_cam_aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not complete", cycle_cnt);
            $display("Some tests failed");
            $finish;
        end
    end

    always @(posedge axi4s_cam_aclk) begin
        m_ready_i <= random_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
    end

    task automatic compare_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // ----------------------------------------
    //  output monitor, sampled mid-cycle
    // ----------------------------------------

    always @(negedge axi4s_cam_aclk) begin
        if (!sys_reset && m_valid_o && m_ready_i) begin
            chk_cnt++;
            assert (exp_words.size() != 0) else begin
                $display("%0t: output word appeared while none was expected", $time);
                err_cnt++;
            end
            if (exp_words.size() != 0) begin
                compare_val("m_beat_o.data", m_beat_o.data, exp_words[0].data);
                compare_val("m_beat_o.sof", 32'(m_beat_o.sof), 32'(exp_words[0].sof));
                compare_val("m_beat_o.eol", 32'(m_beat_o.eol), 32'(exp_words[0].eol));
                void'(exp_words.pop_front());
            end
        end
    end

    // ----------------------------------------
    //  register bus
    // ----------------------------------------

    task automatic bus_access(input cam_regs_pkg::wb_adr_t adr, input cam_regs_pkg::wb_dat_t wdat,
            input logic we, output cam_regs_pkg::wb_dat_t rdat);
        int cycles;
        @(posedge axi4s_cam_aclk);
        wb_req_i <= '{adr: adr, dat: wdat, we: we, stb: 1'b1};
        cycles = 0;
        do begin
            @(negedge axi4s_cam_aclk);
            cycles++;
        end while (!wb_ack_o && cycles < 8);
        rdat = wb_dat_o;
        chk_cnt++;
        // stb is sampled at the next edge, ack follows one cycle later
        assert (wb_ack_o && cycles == 2) else begin
            $display("%0t: access to address %0h not acked one cycle after stb", $time, adr);
            err_cnt++;
        end
        @(posedge axi4s_cam_aclk);
        wb_req_i.stb <= 1'b0;
    endtask

    task automatic reg_write(input cam_regs_pkg::wb_adr_t adr, input cam_regs_pkg::wb_dat_t dat);
        cam_regs_pkg::wb_dat_t unused;
        bus_access(adr, dat, 1'b1, unused);
    endtask

    task automatic reg_check(input cam_regs_pkg::wb_adr_t adr, input cam_regs_pkg::wb_dat_t exp,
            input string name);
        cam_regs_pkg::wb_dat_t got;
        bus_access(adr, '0, 1'b0, got);
        compare_val(name, got, exp);
    endtask

    task automatic set_cfg(input int width, input cam_stream_pkg::raw_pix_t fill);
        reg_write(`CAM_REG_WIDTH, width);
        reg_write(`CAM_REG_FILL, 32'(fill));
        cfg_width = width - width % `CAM_WORD_PIX;   // low bits read as zero
        cfg_fill  = fill;
    endtask

    // ----------------------------------------
    //  input stream
    // ----------------------------------------

    // called right after a rising edge, returns on the edge where the beat moves
    task automatic push_beat(input cam_stream_pkg::raw_beat_t b);
        int gap;
        gap = $urandom_range(0, 2);
        repeat (gap) begin
            s_valid_i <= 1'b0;
            @(posedge axi4s_cam_aclk);
        end
        s_beat_i  <= b;
        s_valid_i <= 1'b1;
        @(negedge axi4s_cam_aclk);
        while (!s_ready_o) @(negedge axi4s_cam_aclk);
        @(posedge axi4s_cam_aclk);
    endtask

    task automatic send_line(input int len, input bit sof, input bit expect_out);
        pix_list_t                 line;
        cam_stream_pkg::raw_beat_t b;
        int                        i;
        for (i = 0; i < len; i++) begin
            line.push_back(cam_stream_pkg::raw_pix_t'($urandom_range(0, 1023)));
        end
        if (expect_out) begin
            queue_line(line, sof, cfg_width, cfg_fill);
            if (sof) frames_sent++;
        end
        for (i = 0; i < len; i++) begin
            b.pix = line[i];
            b.sof = sof && (i == 0);
            b.eol = (i == len - 1);
            push_beat(b);
        end
    endtask

    task automatic send_frame(input int lines, input int min_len, input int max_len,
            input bit expect_out);
        int l;
        int len;
        for (l = 0; l < lines; l++) begin
            len = $urandom_range(max_len, min_len);
            send_line(len, l == 0, expect_out);
        end
    endtask

    task automatic drain();
        s_valid_i <= 1'b0;
        while (exp_words.size() != 0) @(negedge axi4s_cam_aclk);
        @(posedge axi4s_cam_aclk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_cnt != err_mark) fail_tests++;
        $display("test %-12s %s, %0d errors", name,
                 (err_cnt == err_mark) ? "ok" : "FAILED", err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    initial begin
        cam_stream_pkg::raw_pix_t fill_val;
        void'($urandom(32'hc5f8));
        sys_reset <= 1'b1;
        wb_req_i  <= '0;
        s_beat_i  <= '0;
        s_valid_i <= 1'b0;
        m_ready_i <= 1'b1;
        repeat (16) @(posedge axi4s_cam_aclk);
        sys_reset <= 1'b0;

        reg_check(`CAM_REG_ID, `CAM_CORE_ID, "ID");
        reg_write(`CAM_REG_WIDTH, 23);
        reg_check(`CAM_REG_WIDTH, 20, "WIDTH");
        fill_val = cam_stream_pkg::raw_pix_t'($urandom_range(0, 1023));
        reg_write(`CAM_REG_FILL, 32'(fill_val));
        reg_check(`CAM_REG_FILL, 32'(fill_val), "FILL");
        reg_write(8'h3c, 32'hffff_ffff);
        reg_check(8'h3c, 0, "unmapped");
        finish_test("registers");

        set_cfg(16, 10'h2a5);
        reg_write(`CAM_REG_CTRL, 1);
        repeat (2) send_frame(4, 16, 16, 1'b1);
        drain();
        finish_test("exact");

        set_cfg(20, cam_stream_pkg::raw_pix_t'($urandom_range(0, 1023)));
        repeat (2) send_frame(4, 1, 19, 1'b1);
        drain();
        finish_test("short");

        set_cfg(12, 10'h155);
        random_ready = 1'b1;
        repeat (2) send_frame(4, 13, 32, 1'b1);
        drain();
        finish_test("long");

        set_cfg(22, cam_stream_pkg::raw_pix_t'($urandom_range(0, 1023)));
        repeat (6) send_frame(4, 1, 32, 1'b1);
        drain();
        finish_test("stalls");

        random_ready = 1'b0;
        reg_check(`CAM_REG_FRAMES, frames_sent, "FRAMES");
        reg_write(`CAM_REG_CTRL, 0);
        send_frame(4, 1, 32, 1'b0);
        drain();
        repeat (8) @(posedge axi4s_cam_aclk);   // room for a stray word to show up
        reg_check(`CAM_REG_FRAMES, frames_sent, "FRAMES");
        reg_write(`CAM_REG_CTRL, 2);
        reg_check(`CAM_REG_FRAMES, 0, "FRAMES");
        finish_test("frames");

        $display("tests: %0d run, %0d with errors; checks: %0d, errors: %0d",
                 tests_run, fail_tests, chk_cnt, err_cnt);
        if (fail_tests == 0 && err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+hw
+incdir+verif
hw/cam_stream_pkg.sv
hw/cam_regs_pkg.sv
hw/cam_reg_block.sv
hw/line_regularizer.sv
hw/pixel_packer.sv
hw/cam_capture_top.sv
verif/tb_cam_capture.sv

/* run_sim.sh */
#!/bin/sh
# build and run the camera capture testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cam_capture \
    -f sources.f -o tb_cam_capture
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cam_capture > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
    exit 0
fi
exit 1
